//--- jesd_rx_pkg.sv
`default_nettype none

package jesd_rx_pkg;

  // *************************************************************************
  // Link geometry
  // *************************************************************************

  // Lanes in the link, each one delivers four octets per device clock
  localparam int NUM_LANES = 4;

  // Converter count M
  localparam int NUM_CONV = 2;

  // Converter resolution in bits
  localparam int SAMPLE_W = 16;

  // Samples per converter per device clock, lanes times 32 bits shared over M
  localparam int SAMPLES_PER_CONV = NUM_LANES * 32 / NUM_CONV / SAMPLE_W;

  // One lane word, octet 0 sits in the low byte
  typedef logic [31:0] lane_word_t;

  // One converter sample
  typedef logic [SAMPLE_W-1:0] sample_t;

  // All samples of one cycle, slice k holds sample index k
  typedef logic [NUM_CONV*SAMPLES_PER_CONV*SAMPLE_W-1:0] sample_word_t;

  // Index of a physical lane as used by the crossbar map
  typedef logic [$clog2(NUM_LANES)-1:0] lane_sel_t;

  // *************************************************************************
  // Control characters and link states
  // *************************************************************************

  // K28.5 fills the lanes during code-group synchronisation
  localparam logic [7:0] CHAR_K28_5 = 8'hBC;

  // K28.0 marks the first octet of the initial lane alignment sequence
  localparam logic [7:0] CHAR_K28_0 = 8'h1C;

  typedef enum logic [1:0] {
    LINK_CGS,
    LINK_SYNCED,
    LINK_ILAS,
    LINK_DATA
  } link_state_t;

endpackage

`default_nettype wire

//--- jesd_lane_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Lane words after remap and polarity correction, synchronous to device_clk
interface lane_bus_if import jesd_rx_pkg::*; ();

  // Corrected lane words, index is the logical lane
  lane_word_t lanes [NUM_LANES];

  // High from the first cycle after reset, the bus then carries live words
  logic valid;

  // Per lane, all four octets of the word are K28.5
  logic [NUM_LANES-1:0] cgs_char;

  // Per lane, octet 0 of the word is K28.0
  logic [NUM_LANES-1:0] ilas_start;

  // The crossbar owns every signal on the bus
  modport src (
    output lanes,
    output valid,
    output cgs_char,
    output ilas_start
  );

  // The link state machine only looks at the character flags
  modport ctrl (
    input valid,
    input cgs_char,
    input ilas_start
  );

  // The deframer only needs the payload
  modport sink (
    input lanes
  );

endinterface

`default_nettype wire

//--- jesd_lane_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_lane_xbar import jesd_rx_pkg::*; (
  input  logic                 device_clk,
  input  logic                 rst_n,
  input  lane_word_t           lane_in [NUM_LANES],
  input  lane_sel_t            lane_map [NUM_LANES],
  input  logic [NUM_LANES-1:0] lane_invert,
  lane_bus_if.src              bus
);

  // Lane words after selection and inversion, before the register stage
  lane_word_t lane_fix [NUM_LANES];

  // *************************************************************************
  // Remap and polarity correction
  // *************************************************************************

  // Logical lane i is taken from physical lane lane_map[i]
  // lane_invert[i] belongs to the logical lane i and undoes a P/N swap on the board
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_invert[i]) begin
        lane_fix[i] = ~lane_in[lane_map[i]];
      end else begin
        lane_fix[i] = lane_in[lane_map[i]];
      end
    end
  end

  // Payload register, the bus lags lane_in by one device clock
  always_ff @(posedge device_clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      bus.lanes[i] <= lane_fix[i];
    end
  end

  // *************************************************************************
  // Control character detection
  // *************************************************************************

  // The flags are computed from the corrected words so they line up with the payload
  always_ff @(posedge device_clk) begin
    if (!rst_n) begin
      bus.valid      <= 1'b0;
      bus.cgs_char   <= '0;
      bus.ilas_start <= '0;
    end else begin
      bus.valid <= 1'b1;
      for (int i = 0; i < NUM_LANES; i++) begin
        // A code-group sync word is K28.5 in every octet
        bus.cgs_char[i]   <= lane_fix[i] == {4{CHAR_K28_5}};
        // ILAS starts with K28.0 in the first octet of the multiframe
        bus.ilas_start[i] <= lane_fix[i][7:0] == CHAR_K28_0;
      end
    end
  end

endmodule

`default_nettype wire

//--- jesd_lmfc_timer.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_lmfc_timer #(
  parameter int K_WORDS = 8
) (
  input  logic       device_clk,
  input  logic       rst_n,
  input  logic       mf_restart,
  output logic       lmfc_edge,
  output logic [2:0] mf_count
);

  localparam int WORD_W = (K_WORDS > 1) ? $clog2(K_WORDS) : 1;

  // Index of the next word within its multiframe
  logic [WORD_W-1:0] word_cnt;

  // Index of the word on the bus this cycle
  logic [WORD_W-1:0] word_idx;

  // A restart makes the current word, the ILAS start word, word 0 of a multiframe
  assign word_idx = mf_restart ? '0 : word_cnt;

  // Pulse on the last word of every multiframe
  assign lmfc_edge = word_idx == WORD_W'(K_WORDS - 1);

  always_ff @(posedge device_clk) begin
    if (!rst_n) begin
      word_cnt <= '0;
      mf_count <= '0;
    end else begin
      // Wrap after the last word, otherwise step on
      if (lmfc_edge) begin
        word_cnt <= '0;
      end else begin
        word_cnt <= word_idx + 1'b1;
      end

      // Completed multiframes since the restart, held at 7
      if (mf_restart) begin
        mf_count <= lmfc_edge ? 3'd1 : 3'd0;
      end else if (lmfc_edge && (mf_count != 3'd7)) begin
        mf_count <= mf_count + 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- jesd_link_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_link_fsm import jesd_rx_pkg::*; #(
  parameter int CGS_WORDS        = 4,
  parameter int ILAS_MULTIFRAMES = 4
) (
  input  logic       device_clk,
  input  logic       rst_n,
  lane_bus_if.ctrl   bus,
  input  logic       lmfc_edge,
  input  logic [2:0] mf_count,
  output logic       mf_restart,
  output logic       sync_n,
  output logic       link_up
);

  localparam int CGS_W = $clog2(CGS_WORDS + 1);

  link_state_t state;

  // Consecutive all-lanes K28.5 words seen so far in LINK_CGS
  logic [CGS_W-1:0] cgs_cnt;

  logic all_k;
  logic all_ilas;
  logic ilas_done;

  // *************************************************************************
  // Lane conditions
  // *************************************************************************

  // Every lane shows a full K28.5 word
  assign all_k = bus.valid && (&bus.cgs_char);

  // Every lane starts its ILAS in the same cycle
  assign all_ilas = bus.valid && (&bus.ilas_start);

  // Last word of the final ILAS multiframe, mf_count still holds the frames before it
  assign ilas_done = lmfc_edge && (mf_count == 3'(ILAS_MULTIFRAMES - 1));

  // The ILAS start word itself aligns the multiframe timer
  assign mf_restart = (state == LINK_SYNCED) && all_ilas;

  // sync_n stays low only while code groups are still being searched
  assign sync_n = state != LINK_CGS;

  // Words on the bus are sample data exactly while link_up is high
  assign link_up = state == LINK_DATA;

  // *************************************************************************
  // State register
  // *************************************************************************

  always_ff @(posedge device_clk) begin
    if (!rst_n) begin
      state   <= LINK_CGS;
      cgs_cnt <= '0;
    end else begin
      case (state)
        LINK_CGS: begin
          // Any word that is not all K28.5 breaks the run
          if (all_k) begin
            if (cgs_cnt == CGS_W'(CGS_WORDS - 1)) begin
              state   <= LINK_SYNCED;
              cgs_cnt <= '0;
            end else begin
              cgs_cnt <= cgs_cnt + 1'b1;
            end
          end else begin
            cgs_cnt <= '0;
          end
        end
        LINK_SYNCED: begin
          // The transmitter keeps sending K28.5 until it sees sync_n high
          if (all_ilas) begin
            state <= LINK_ILAS;
          end
        end
        LINK_ILAS: begin
          if (all_k) begin
            state <= LINK_CGS;
          end else if (ilas_done) begin
            state <= LINK_DATA;
          end
        end
        LINK_DATA: begin
          // The transmitter falls back to K28.5 when it has lost the link
          // A fresh run starts with the word after this one
          if (all_k) begin
            state <= LINK_CGS;
          end
        end
        default: begin
          state <= LINK_CGS;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- jesd_deframer.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_deframer import jesd_rx_pkg::*; (
  input  logic         device_clk,
  input  logic         rst_n,
  lane_bus_if.sink     bus,
  input  logic         link_up,
  output logic         frame_valid,
  output sample_word_t frame_data
);

  localparam int NUM_SAMPLES = NUM_CONV * SAMPLES_PER_CONV;
  localparam int LANE_BITS   = $bits(lane_word_t);

  // Lanes 0 to 3 side by side, lane 0 in the low bits
  sample_word_t lane_flat;

  // 16-bit slices in link order, converters interleaved per sample
  sample_t in_slice [NUM_SAMPLES];

  // Same samples grouped by converter
  sample_word_t conv_major;

  // *************************************************************************
  // Sample reordering
  // *************************************************************************

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_flat[l*LANE_BITS +: LANE_BITS] = bus.lanes[l];
    end
    for (int k = 0; k < NUM_SAMPLES; k++) begin
      in_slice[k] = lane_flat[k*SAMPLE_W +: SAMPLE_W];
    end
    // Link slice s*M + m carries converter m, sample s
    for (int m = 0; m < NUM_CONV; m++) begin
      for (int s = 0; s < SAMPLES_PER_CONV; s++) begin
        conv_major[(m*SAMPLES_PER_CONV+s)*SAMPLE_W +: SAMPLE_W] = in_slice[s*NUM_CONV+m];
      end
    end
  end

  // Payload register
  always_ff @(posedge device_clk) begin
    frame_data <= conv_major;
  end

  // Only words seen during the data phase go on to the FIFO
  always_ff @(posedge device_clk) begin
    if (!rst_n) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= link_up;
    end
  end

endmodule

`default_nettype wire

//--- jesd_sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_sample_fifo import jesd_rx_pkg::*; #(
  parameter int FIFO_DEPTH = 8,
  parameter int CREDITS    = 4
) (
  input  logic         device_clk,
  input  logic         rst_n,
  input  logic         frame_valid,
  input  sample_word_t frame_data,
  output logic         sample_valid,
  output sample_word_t sample_data,
  input  logic         credit_return,
  output logic         overflow
);

  localparam int PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int LEVEL_W  = $clog2(FIFO_DEPTH + 1);
  localparam int CREDIT_W = $clog2(CREDITS + 1);

  sample_word_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [LEVEL_W-1:0]  level;
  logic [CREDIT_W-1:0] credit_cnt;

  logic empty;
  logic full;
  logic out_load;
  logic bypass;
  logic pop;
  logic push;
  logic drop;

  // *************************************************************************
  // Flow decisions
  // *************************************************************************

  assign empty = level == '0;
  assign full  = level == LEVEL_W'(FIFO_DEPTH);

  // A word goes to the output stage whenever downstream holds a credit for it
  assign out_load = (credit_cnt != '0) && (!empty || frame_valid);

  // An incoming word skips the buffer when nothing is queued ahead of it
  assign bypass = out_load && empty;
  assign pop    = out_load && !empty;

  // A word that is not forwarded at once is queued, or lost when no slot frees up
  assign push = frame_valid && !bypass && (!full || pop);
  assign drop = frame_valid && !bypass && full && !pop;

  // *************************************************************************
  // Buffer storage and output stage
  // *************************************************************************

  always_ff @(posedge device_clk) begin
    if (push) begin
      mem[wr_ptr] <= frame_data;
    end
    if (bypass) begin
      sample_data <= frame_data;
    end else if (pop) begin
      sample_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge device_clk) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      level        <= '0;
      credit_cnt   <= CREDIT_W'(CREDITS);
      sample_valid <= 1'b0;
      overflow     <= 1'b0;
    end else begin
      sample_valid <= out_load;

      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end

      // Occupancy follows pushes and pops, both may happen in one cycle
      if (push && !pop) begin
        level <= level + 1'b1;
      end else if (pop && !push) begin
        level <= level - 1'b1;
      end

      // One credit per word sent, one back per return pulse
      if (out_load && !credit_return) begin
        credit_cnt <= credit_cnt - 1'b1;
      end else if (credit_return && !out_load) begin
        credit_cnt <= credit_cnt + 1'b1;
      end

      // Sticky until reset so software can see that data was lost
      if (drop) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- jesd_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_rx_top import jesd_rx_pkg::*; #(
  parameter int K_WORDS          = 8,
  parameter int ILAS_MULTIFRAMES = 4,
  parameter int CGS_WORDS        = 4,
  parameter int FIFO_DEPTH       = 8,
  parameter int CREDITS          = 4
) (
  input  logic                 device_clk,
  input  logic                 rst_n,
  input  lane_word_t           lane_in [NUM_LANES],
  input  lane_sel_t            lane_map [NUM_LANES],
  input  logic [NUM_LANES-1:0] lane_invert,
  output logic                 sync_n,
  output logic                 link_up,
  output logic                 sample_valid,
  output sample_word_t         sample_data,
  input  logic                 credit_return,
  output logic                 overflow
);

  // Timer handshake between the state machine and the multiframe counter
  logic       mf_restart;
  logic       lmfc_edge;
  logic [2:0] mf_count;

  // Deframed words on their way into the FIFO
  logic         frame_valid;
  sample_word_t frame_data;

  // Corrected lane words shared by the state machine and the deframer
  lane_bus_if i_lane_bus ();

  jesd_lane_xbar i_jesd_lane_xbar (
    .device_clk  (device_clk),
    .rst_n       (rst_n),
    .lane_in     (lane_in),
    .lane_map    (lane_map),
    .lane_invert (lane_invert),
    .bus         (i_lane_bus.src)
  );

  jesd_lmfc_timer #(
    .K_WORDS (K_WORDS)
  ) i_jesd_lmfc_timer (
    .device_clk (device_clk),
    .rst_n      (rst_n),
    .mf_restart (mf_restart),
    .lmfc_edge  (lmfc_edge),
    .mf_count   (mf_count)
  );

  jesd_link_fsm #(
    .CGS_WORDS        (CGS_WORDS),
    .ILAS_MULTIFRAMES (ILAS_MULTIFRAMES)
  ) i_jesd_link_fsm (
    .device_clk (device_clk),
    .rst_n      (rst_n),
    .bus        (i_lane_bus.ctrl),
    .lmfc_edge  (lmfc_edge),
    .mf_count   (mf_count),
    .mf_restart (mf_restart),
    .sync_n     (sync_n),
    .link_up    (link_up)
  );

  jesd_deframer i_jesd_deframer (
    .device_clk  (device_clk),
    .rst_n       (rst_n),
    .bus         (i_lane_bus.sink),
    .link_up     (link_up),
    .frame_valid (frame_valid),
    .frame_data  (frame_data)
  );

  jesd_sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CREDITS    (CREDITS)
  ) i_jesd_sample_fifo (
    .device_clk    (device_clk),
    .rst_n         (rst_n),
    .frame_valid   (frame_valid),
    .frame_data    (frame_data),
    .sample_valid  (sample_valid),
    .sample_data   (sample_data),
    .credit_return (credit_return),
    .overflow      (overflow)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running device clock for the testbench
module tb_clock_gen #(
  parameter realtime PERIOD_NS = 40.0
) (
  output logic clk
);

  // Start low so the first rising edge lands half a period in
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- jesd_rx_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// Flow-control rules of the sample FIFO, checked on every device clock
module jesd_rx_assertions #(
  parameter int CREDITS = 4
) (
  input logic                           device_clk,
  input logic                           rst_n,
  input logic                           sample_valid,
  input logic                           credit_return,
  input logic                           overflow,
  input logic [$clog2(CREDITS+1)-1:0]   credit_cnt
);

  // Credits downstream holds as seen on the handshake pins
  // Each word shown takes one away and each return pulse gives one back
  int granted;

  always_ff @(posedge device_clk) begin
    if (!rst_n) begin
      granted <= CREDITS;
    end else begin
      granted <= granted - int'(sample_valid) + int'(credit_return);
    end
  end

  // A word may only leave against a credit that downstream has granted
  property p_credit_before_valid;
    @(posedge device_clk) disable iff (!rst_n)
      sample_valid |-> (granted > 0);
  endproperty

  // Lost data stays visible until the next reset
  property p_overflow_sticky;
    @(posedge device_clk) disable iff (!rst_n)
      !$fell(overflow);
  endproperty

  // Downstream can never hand back more credits than it was given
  property p_credit_bound;
    @(posedge device_clk) disable iff (!rst_n)
      int'(credit_cnt) <= CREDITS;
  endproperty

  a_credit_before_valid: assert property (p_credit_before_valid)
    else $error("sample_valid without a credit");
  a_overflow_sticky: assert property (p_overflow_sticky)
    else $error("overflow fell while out of reset");
  a_credit_bound: assert property (p_credit_bound)
    else $error("credit count above its limit");

endmodule

bind jesd_sample_fifo jesd_rx_assertions #(
  .CREDITS (CREDITS)
) i_jesd_rx_assertions (
  .device_clk    (device_clk),
  .rst_n         (rst_n),
  .sample_valid  (sample_valid),
  .credit_return (credit_return),
  .overflow      (overflow),
  .credit_cnt    (credit_cnt)
);

`default_nettype wire

//--- jesd_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_rx_tb import jesd_rx_pkg::*; ;

  localparam int K_WORDS          = 8;
  localparam int ILAS_MULTIFRAMES = 4;
  localparam int CGS_WORDS        = 4;
  localparam int FIFO_DEPTH       = 8;
  localparam int CREDITS          = 4;

  localparam int MODE_PROMPT = 0;
  localparam int MODE_HOLD   = 1;
  localparam int MODE_RANDOM = 2;
  localparam int NUM_ROWS    = 6;

  // One test row, map packs lane_map[i] into bits 2i+1:2i
  typedef struct {
    logic [7:0] map;
    logic [3:0] inv;
    int         words;
    int         mode;
    int         hold;
    bit         loss;
  } row_t;

  logic                 device_clk;
  logic                 rst_n;
  lane_word_t           lane_in [NUM_LANES];
  lane_sel_t            lane_map [NUM_LANES];
  logic [NUM_LANES-1:0] lane_invert;
  logic                 sync_n;
  logic                 link_up;
  logic                 sample_valid;
  sample_word_t         sample_data;
  logic                 credit_return;
  logic                 overflow;

  row_t         rows [NUM_ROWS];
  sample_word_t exp_q [$];
  lane_word_t   tx_word [NUM_LANES];
  logic [7:0]   cur_map;
  logic [3:0]   cur_inv;
  logic [15:0]  base;
  bit           data_phase;
  bit           ovf_seen;
  int           credit_mode;
  int           hold_left;
  int           owed;
  int           rx_count;
  int           mismatch_count;
  int           fail_count;

  tb_clock_gen #(.PERIOD_NS(40.0)) i_tb_clock_gen (.clk(device_clk));

  jesd_rx_top #(
    .K_WORDS          (K_WORDS),
    .ILAS_MULTIFRAMES (ILAS_MULTIFRAMES),
    .CGS_WORDS        (CGS_WORDS),
    .FIFO_DEPTH       (FIFO_DEPTH),
    .CREDITS          (CREDITS)
  ) i_jesd_rx_top (
    .device_clk    (device_clk),
    .rst_n         (rst_n),
    .lane_in       (lane_in),
    .lane_map      (lane_map),
    .lane_invert   (lane_invert),
    .sync_n        (sync_n),
    .link_up       (link_up),
    .sample_valid  (sample_valid),
    .sample_data   (sample_data),
    .credit_return (credit_return),
    .overflow      (overflow)
  );

  // ***************************************************************************
  // Pattern model
  // ***************************************************************************

  // Logical lane l carries samples 2l and 2l+1 of the interleaved pattern
  function automatic lane_word_t data_lane(input logic [15:0] b, input int l);
    logic [15:0] lo;
    lo = b + 16'(2 * l);
    return {lo + 16'd1, lo};
  endfunction

  // Converter m, sample s is the base plus s*M + m
  function automatic sample_word_t frame_of(input logic [15:0] b);
    sample_word_t f;
    for (int m = 0; m < NUM_CONV; m++) begin
      for (int s = 0; s < SAMPLES_PER_CONV; s++) begin
        f[(m*SAMPLES_PER_CONV+s)*16 +: 16] = b + 16'(s * NUM_CONV + m);
      end
    end
    return f;
  endfunction

  // ***************************************************************************
  // Transmitter side
  // ***************************************************************************

  // Scramble tx_word onto the physical lanes with the inverse of the current map
  task automatic send_word();
    lane_sel_t idx;
    @(posedge device_clk);
    #2;
    lane_invert = cur_inv;
    for (int i = 0; i < NUM_LANES; i++) begin
      idx = cur_map[2*i +: 2];
      lane_map[i] = idx;
      lane_in[idx] = cur_inv[i] ? ~tx_word[i] : tx_word[i];
    end
  endtask

  task automatic send_fill(input lane_word_t w);
    for (int i = 0; i < NUM_LANES; i++) begin
      tx_word[i] = w;
    end
    send_word();
  endtask

  // The first K28.5 word after data is still seen while link_up is high
  task automatic send_k();
    if (data_phase) begin
      exp_q.push_back({8{16'hBCBC}});
      data_phase = 1'b0;
    end
    send_fill({4{CHAR_K28_5}});
  endtask

  // Code-group sync until sync_n is released, then one ILAS of fixed length
  task automatic bring_up();
    int n;
    n = 0;
    do begin
      send_k();
      n++;
    end while (!sync_n && n < CGS_WORDS + 16);
    if (!sync_n) begin
      $display("sync_n did not rise after %0d K28.5 words", n);
      fail_count++;
    end
    send_fill({24'h0, CHAR_K28_0});
    repeat (ILAS_MULTIFRAMES * K_WORDS - 1) begin
      send_fill(32'h0);
    end
    if (link_up) begin
      $display("link_up rose before the ILAS was complete");
      fail_count++;
    end
    data_phase = 1'b1;
  endtask

  task automatic send_data(input int n);
    for (int j = 0; j < n; j++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        tx_word[l] = data_lane(base, l);
      end
      exp_q.push_back(frame_of(base));
      send_word();
      base = base + 16'd8;
      // The first data word is on the bus in the cycle link_up rises
      if (j == 1 && !link_up) begin
        $display("link_up did not rise after the ILAS");
        fail_count++;
      end
    end
  endtask

  // ***************************************************************************
  // Row sequence
  // ***************************************************************************

  task automatic run_row(input int r);
    logic ovf_before;
    bit   ovf_expected;
    int   quiet;
    int   last;
    int   n;
    cur_map     = rows[r].map;
    cur_inv     = rows[r].inv;
    credit_mode = rows[r].mode;
    ovf_before  = overflow;
    // Held credits plus a full FIFO absorb fewer words than the row sends
    ovf_expected = rows[r].mode == MODE_HOLD &&
                   rows[r].words + 1 > CREDITS + FIFO_DEPTH;
    bring_up();
    rx_count = 0;
    if (rows[r].mode == MODE_HOLD) begin
      hold_left = rows[r].hold;
    end
    if (rows[r].loss) begin
      send_data(rows[r].words / 2);
      // link_up and sync_n fall one cycle after the first K28.5 word reaches the bus
      send_k();
      send_k();
      send_k();
      if (link_up || sync_n) begin
        $display("link loss not seen, link_up %0b sync_n %0b", link_up, sync_n);
        fail_count++;
      end
      bring_up();
      send_data(rows[r].words - rows[r].words / 2);
    end else begin
      send_data(rows[r].words);
    end
    send_k();

    // With credits held back only the initial credits may have been used
    if (rows[r].mode == MODE_HOLD) begin
      while (hold_left > 1) begin
        send_k();
      end
      if (rx_count != CREDITS) begin
        $display("mismatch rx_count: got %h expected %h", rx_count, CREDITS);
        mismatch_count++;
      end
      if (ovf_expected && !overflow) begin
        $display("overflow did not rise with the FIFO full");
        fail_count++;
      end else if (!ovf_expected && overflow && !ovf_before) begin
        $display("overflow rose although the FIFO had room");
        fail_count++;
      end
    end

    // Idle K28.5 words while the FIFO drains
    quiet = 0;
    n = 0;
    while (exp_q.size() > 0 && quiet < 40 && n < 1000) begin
      last = rx_count;
      send_k();
      quiet = (rx_count == last) ? quiet + 1 : 0;
      n++;
    end
    // Words dropped by an overflow never show up
    if (exp_q.size() > 0) begin
      if (!ovf_expected) begin
        $display("row %0d: %0d words never delivered", r, exp_q.size());
        fail_count++;
      end
      exp_q.delete();
    end
  endtask

  // ***************************************************************************
  // Checker and credit return
  // ***************************************************************************

  always @(posedge device_clk) begin
    sample_word_t exp;
    if (rst_n) begin
      if (ovf_seen && !overflow) begin
        $display("overflow fell while out of reset");
        fail_count++;
      end
      if (overflow) begin
        ovf_seen = 1'b1;
      end
      if (sample_valid) begin
        rx_count++;
        if (exp_q.size() == 0) begin
          $display("sample_valid with no word outstanding");
          fail_count++;
        end else begin
          exp = exp_q.pop_front();
          for (int k = 0; k < NUM_CONV * SAMPLES_PER_CONV; k++) begin
            if (sample_data[k*16 +: 16] !== exp[k*16 +: 16]) begin
              $display("mismatch sample_data[%0d]: got %h expected %h",
                       k, sample_data[k*16 +: 16], exp[k*16 +: 16]);
              mismatch_count++;
            end
          end
        end
      end
    end
  end

  // Downstream hands back one credit per word it received, one per cycle
  always @(posedge device_clk) begin
    if (rst_n && sample_valid) begin
      owed++;
    end
    if (hold_left > 0) begin
      hold_left--;
    end
    #2;
    if (owed > 0 && hold_left == 0 &&
        (credit_mode != MODE_RANDOM || $urandom_range(2, 0) != 0)) begin
      credit_return = 1'b1;
      owed--;
    end else begin
      credit_return = 1'b0;
    end
  end

  // ***************************************************************************
  // Main sequence and watchdog
  // ***************************************************************************

  initial begin
    void'($urandom(32'h2cba));
    rows[0] = '{8'hE4, 4'b0000, 12, MODE_PROMPT, 0, 1'b0};
    rows[1] = '{8'hB1, 4'b0101, 12, MODE_PROMPT, 0, 1'b1};
    rows[2] = '{8'h1B, 4'b1111, 10, MODE_HOLD, 40, 1'b0};
    rows[3] = '{8'h4E, 4'b0010, 16, MODE_RANDOM, 0, 1'b0};
    rows[4] = '{8'h39, 4'b1000, 20, MODE_HOLD, 60, 1'b0};
    rows[5] = '{8'hE4, 4'b0000, 8, MODE_PROMPT, 0, 1'b1};
    rst_n = 1'b0;
    credit_return = 1'b0;
    lane_invert = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_in[i] = '0;
      lane_map[i] = lane_sel_t'(i);
    end
    cur_map = 8'hE4;
    cur_inv = 4'b0000;
    base = 16'h0100;
    data_phase = 1'b0;
    ovf_seen = 1'b0;
    credit_mode = MODE_PROMPT;
    hold_left = 0;
    owed = 0;
    rx_count = 0;
    mismatch_count = 0;
    fail_count = 0;

    repeat (16) @(posedge device_clk);
    #2;
    rst_n = 1'b1;
    @(posedge device_clk);
    #2;
    if (sync_n || link_up || sample_valid || overflow) begin
      $display("mismatch reset outputs {sync_n,link_up,sample_valid,overflow}: got %h expected %h",
               {sync_n, link_up, sample_valid, overflow}, 4'h0);
      mismatch_count++;
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Limit scales with the data words in the table plus bring-up per row
  initial begin
    int total;
    #1;
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += rows[r].words;
    end
    repeat ((total + NUM_ROWS) * 40 + 2000) @(posedge device_clk);
    $display("timeout: the test sequence did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
jesd_rx_pkg.sv
jesd_lane_bus_if.sv
jesd_lane_xbar.sv
jesd_lmfc_timer.sv
jesd_link_fsm.sv
jesd_deframer.sv
jesd_sample_fifo.sv
jesd_rx_top.sv
tb_clock_gen.sv
jesd_rx_assertions.sv
jesd_rx_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -f tb.f --top-module jesd_rx_tb -o jesd_rx_sim
	./obj_dir/jesd_rx_sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
